// File: hdl/crosspoint_pkg.sv
package crosspoint_pkg;

	// switch geometry.
	localparam int num_outputs = 8;
	localparam int sel_width   = 4;
	localparam int entry_width = sel_width + 1;              // enable bit on top of the select.
	localparam int frame_width = num_outputs * entry_width;

	// slave port.
	localparam int addr_width = $clog2(num_outputs);

	// serial clock timing, in system clocks per half period.
	localparam int clk_half_period = 2;

	// counter widths derived from the timing and the frame length.
	localparam int half_cnt_width = $clog2(clk_half_period + 1);
	localparam int bit_cnt_width  = $clog2(frame_width + 1);

	// total busy time of one transfer in system clocks.
	// it covers 40 serial periods, the update half period and the closing half period.
	localparam int transfer_clocks = (2 * frame_width + 2) * clk_half_period;

	// kind of a slave write, taken from write data bit 7.
	typedef enum logic
	{
		cmd_set_output = 1'b0,
		cmd_load       = 1'b1
	} cmd_e;

	// shifter sequence.
	// st_shift clocks out the frame, st_update holds the strobe low,
	// st_finish gives the switch one more half period before busy drops.
	typedef enum logic [1:0]
	{
		st_idle   = 2'd0,
		st_shift  = 2'd1,
		st_update = 2'd2,
		st_finish = 2'd3
	} shift_state_e;

endpackage

// File: hdl/crosspoint_regs.sv
module crosspoint_regs (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic                                   write,
	input  logic [crosspoint_pkg::addr_width-1:0]  address,
	input  logic [7:0]                             writedata,
	input  logic                                   busy,
	output logic [crosspoint_pkg::frame_width-1:0] frame,
	output logic                                   start
);

	import crosspoint_pkg::*;

	logic [entry_width-1:0] entries [num_outputs];
	cmd_e                   cmd;
	logic                   write_accept;
	logic                   set_accept;
	logic                   load_accept;
	logic [entry_width-1:0] new_entry;

	assign cmd = cmd_e'(writedata[7]);

	// nothing is accepted while a transfer is running.
	assign write_accept = write && !busy;

	assign set_accept = write_accept && (cmd == cmd_set_output);

	// a second load in the cycle that start is still high would land on a running shifter.
	assign load_accept = write_accept && (cmd == cmd_load) && !start;

	// the switch wants an enable bit, software writes a disable flag in bit 4.
	assign new_entry = {~writedata[sel_width], writedata[sel_width-1:0]};

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < num_outputs; i++)
			begin
				entries[i] <= '0;
			end
		end
		else if (set_accept)
		begin
			entries[address] <= new_entry;
		end
	end

	// start is a registered pulse, so busy follows one edge after the load write.
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			start <= 1'b0;
		end
		else
		begin
			start <= load_accept;
		end
	end

	// entry 7 goes to the top of the frame and is shifted out first.
	always_comb
	begin
		for (int i = 0; i < num_outputs; i++)
		begin
			frame[i*entry_width +: entry_width] = entries[i];
		end
	end

endmodule

// File: hdl/serial_shifter.sv
module serial_shifter (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic                                   start,
	input  logic [crosspoint_pkg::frame_width-1:0] frame,
	output logic                                   busy,
	output logic                                   cps_clk,
	output logic                                   cps_update_n,
	output logic                                   cps_datain
);

	import crosspoint_pkg::*;

	shift_state_e              state;
	logic [half_cnt_width-1:0] half_cnt;
	logic [bit_cnt_width-1:0]  bit_cnt;
	logic [frame_width-1:0]    shift_reg;
	logic                      half_done;
	logic                      last_bit;
	logic                      capture;
	logic                      fall_tick;

	assign half_done = (half_cnt == half_cnt_width'(clk_half_period - 1));
	assign last_bit  = (bit_cnt == bit_cnt_width'(frame_width - 1));

	// start only arrives while idle, so it needs no further check here.
	assign capture = (state == st_idle) && start;

	// end of a high half with bits left, the serial clock falls and the next bit goes out.
	assign fall_tick = (state == st_shift) && half_done && cps_clk && !last_bit;

	assign busy       = (state != st_idle);
	assign cps_datain = shift_reg[frame_width-1];   // MSB first.

	// half-period counter. it runs only while a transfer is in progress.
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			half_cnt <= '0;
		end
		else if ((state == st_idle) || half_done)
		begin
			half_cnt <= '0;
		end
		else
		begin
			half_cnt <= half_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state        <= st_idle;
			cps_clk      <= 1'b1;
			cps_update_n <= 1'b1;
			bit_cnt      <= '0;
		end
		else
		begin
			case (state)
				st_idle:
				begin
					if (start)
					begin
						state   <= st_shift;
						cps_clk <= 1'b0;   // first bit appears with the serial clock low.
						bit_cnt <= '0;
					end
				end

				st_shift:
				begin
					if (half_done)
					begin
						if (!cps_clk)
						begin
							cps_clk <= 1'b1;   // the switch samples on this edge.
						end
						else if (last_bit)
						begin
							// the serial clock stays high from here on.
							state        <= st_update;
							cps_update_n <= 1'b0;
						end
						else
						begin
							cps_clk <= 1'b0;
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end

				st_update:
				begin
					if (half_done)
					begin
						state        <= st_finish;
						cps_update_n <= 1'b1;
					end
				end

				st_finish:
				begin
					if (half_done)
					begin
						state <= st_idle;
					end
				end

				default:
				begin
					state <= st_idle;
				end
			endcase
		end
	end

	// the shift register changes only at the start or together with a falling serial clock.
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			shift_reg <= '0;
		end
		else if (capture)
		begin
			shift_reg <= frame;
		end
		else if (fall_tick)
		begin
			shift_reg <= {shift_reg[frame_width-2:0], 1'b0};
		end
	end

endmodule

// File: hdl/crosspoint_ctrl.sv
module crosspoint_ctrl (
	input  logic                                  clk,
	input  logic                                  reset,

	input  logic                                  write,
	input  logic                                  read,
	input  logic [crosspoint_pkg::addr_width-1:0] address,
	input  logic [7:0]                            writedata,
	output logic [7:0]                            readdata,

	output logic                                  cps_reset_n,
	output logic                                  cps_ce_n,
	output logic                                  cps_clk,
	output logic                                  cps_update_n,
	output logic                                  cps_datain
);

	import crosspoint_pkg::*;

	logic [frame_width-1:0] frame;
	logic                   start;
	logic                   busy;

	// read data is always valid, so the read strobe has no effect on the port.
	assign readdata = {7'b0, busy};

	assign cps_reset_n = ~reset;
	assign cps_ce_n    = 1'b0;   // a single chip, always selected.

	crosspoint_regs u_regs (
		.clk       (clk),
		.reset     (reset),
		.write     (write),
		.address   (address),
		.writedata (writedata),
		.busy      (busy),
		.frame     (frame),
		.start     (start)
	);

	serial_shifter u_shifter (
		.clk          (clk),
		.reset        (reset),
		.start        (start),
		.frame        (frame),
		.busy         (busy),
		.cps_clk      (cps_clk),
		.cps_update_n (cps_update_n),
		.cps_datain   (cps_datain)
	);

endmodule

// File: verification/crosspoint_sva.sv
module crosspoint_sva (
	input logic clk,
	input logic reset,
	input logic busy,
	input logic cps_clk,
	input logic cps_update_n,
	input logic cps_datain
);

	int fail_count = 0;   // read by the testbench top for the closing counts.

	// the serial clock parks high between transfers.
	idle_clock_high: assert property (@(posedge clk) disable iff (reset) !busy |-> cps_clk)
	else
	begin
		fail_count++;
		$error("serial clock is low while the shifter is idle");
	end

	update_inside_busy: assert property (@(posedge clk) disable iff (reset) !cps_update_n |-> busy)
	else
	begin
		fail_count++;
		$error("update strobe is low outside a transfer");
	end

	// the switch samples on the rising edge, so data may only move while the clock is low.
	data_stable_clock_high: assert property (@(posedge clk) disable iff (reset)
		(cps_clk && $past(cps_clk)) |-> $stable(cps_datain))
	else
	begin
		fail_count++;
		$error("serial data changed while the serial clock was high");
	end

endmodule

bind serial_shifter crosspoint_sva sva_i (
	.clk          (clk),
	.reset        (reset),
	.busy         (busy),
	.cps_clk      (cps_clk),
	.cps_update_n (cps_update_n),
	.cps_datain   (cps_datain)
);

// File: verification/tb_frame_checker.sv
module tb_frame_checker (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic                                   cps_clk,
	input  logic                                   cps_update_n,
	input  logic                                   cps_datain,
	input  logic                                   exp_push,
	input  logic [crosspoint_pkg::frame_width-1:0] exp_frame,
	output int                                     error_count,
	output int                                     frame_count,
	output int                                     pending
);

	import crosspoint_pkg::*;

	logic [frame_width-1:0] expected_q [$];
	logic [frame_width-1:0] captured;
	logic [frame_width-1:0] expected;
	logic                   cps_clk_q;
	logic                   update_n_q;
	int                     bit_count;

	// pins are read on the system clock, one edge after they were driven.
	always @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			expected_q.delete();
			captured = '0;
			bit_count = 0;
			error_count = 0;
			frame_count = 0;
			pending = 0;
			cps_clk_q <= 1'b1;
			update_n_q <= 1'b1;
		end
		else
		begin
			if (exp_push)
			begin
				expected_q.push_back(exp_frame);
			end
			if (cps_clk && !cps_clk_q)   // rising serial clock, the switch takes this bit.
			begin
				captured = {captured[frame_width-2:0], cps_datain};
				bit_count++;
			end
			if (!cps_update_n && update_n_q)
			begin
				frame_count++;
				if (bit_count != frame_width)
				begin
					error_count++;
					$display("update strobe came after %0d serial bits instead of %0d",
						bit_count, frame_width);
				end
				if (expected_q.size() == 0)
				begin
					error_count++;
					$display("update strobe at time %0t with no load pending", $time);
				end
				else
				begin
					expected = expected_q.pop_front();
					if (captured !== expected)
					begin
						error_count++;
						$display("[FAIL] time %0t frame expected %h got %h",
							$time, expected, captured);
					end
				end
				bit_count = 0;
			end
			pending = expected_q.size();
			cps_clk_q <= cps_clk;
			update_n_q <= cps_update_n;
		end
	end

endmodule

// File: verification/tb_crosspoint_ctrl.sv
module tb_crosspoint_ctrl;

	import crosspoint_pkg::*;

	localparam logic [15:0] lfsr_seed = 16'd77;
	localparam int num_rounds = 4;
	localparam int transfer_len = (2 * frame_width + 2) * clk_half_period;
	localparam int idle_limit = 2 * transfer_len;
	localparam int round_len = 3 * (transfer_len + 4 * num_outputs);   // three loads per round.
	localparam int timeout_cycles = 2 * (16 + transfer_len + num_rounds * round_len);

	logic                             clk;
	logic                             reset;
	logic                             write;
	logic                             read;
	logic [addr_width-1:0]            address;
	logic [7:0]                       writedata;
	logic [7:0]                       readdata;
	logic                             cps_reset_n;
	logic                             cps_ce_n;
	logic                             cps_clk;
	logic                             cps_update_n;
	logic                             cps_datain;
	logic                             exp_push;
	logic [frame_width-1:0]           exp_frame;
	int                               frame_errors;
	int                               frames_seen;
	int                               frames_pending;
	int                               tb_errors;
	int                               loads_sent;
	int                               assert_fails;
	logic [15:0]                      lfsr;
	logic [num_outputs-1:0]           model_dis;   // disable flags as software wrote them.
	logic [num_outputs*sel_width-1:0] model_sel;

	crosspoint_ctrl dut_i (
		.clk          (clk),
		.reset        (reset),
		.write        (write),
		.read         (read),
		.address      (address),
		.writedata    (writedata),
		.readdata     (readdata),
		.cps_reset_n  (cps_reset_n),
		.cps_ce_n     (cps_ce_n),
		.cps_clk      (cps_clk),
		.cps_update_n (cps_update_n),
		.cps_datain   (cps_datain)
	);

	tb_frame_checker checker_i (
		.clk          (clk),
		.reset        (reset),
		.cps_clk      (cps_clk),
		.cps_update_n (cps_update_n),
		.cps_datain   (cps_datain),
		.exp_push     (exp_push),
		.exp_frame    (exp_frame),
		.error_count  (frame_errors),
		.frame_count  (frames_seen),
		.pending      (frames_pending)
	);

	always #4 clk = ~clk;

	// fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1.
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int count, output logic [7:0] bits);
		bits = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsr = lfsr_next(lfsr);
			bits = {bits[6:0], lfsr[0]};
		end
	endtask

	// entry 7 on top, each entry is the enable bit over the four select bits.
	function automatic logic [frame_width-1:0] expected_frame(
		input logic [num_outputs-1:0]           dis,
		input logic [num_outputs*sel_width-1:0] sel
	);
		logic [frame_width-1:0] f;
		f = '0;
		for (int i = 0; i < num_outputs; i++)
		begin
			f[i*entry_width + sel_width] = ~dis[i];
			f[i*entry_width +: sel_width] = sel[i*sel_width +: sel_width];
		end
		return f;
	endfunction

	task automatic check_value(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected)
		begin
			tb_errors++;
			$display("[FAIL] time %0t %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected)
		begin
			tb_errors++;
			$display("[FAIL] time %0t %s expected %0d got %0d", $time, name, expected, actual);
		end
	endtask

	// called one unit after a rising edge, returns at the same phase one cycle later.
	task automatic bus_write(input logic [addr_width-1:0] addr, input logic [7:0] data);
		write = 1'b1;
		address = addr;
		writedata = data;
		@(posedge clk);
		#1;
		write = 1'b0;
	endtask

	task automatic set_output(input logic [addr_width-1:0] addr);
		logic [7:0] bits;
		take_bits(5, bits);
		bus_write(addr, {3'b000, bits[4:0]});
		model_dis[addr] = bits[4];
		model_sel[addr*sel_width +: sel_width] = bits[3:0];
	endtask

	task automatic issue_load();
		exp_frame = expected_frame(model_dis, model_sel);
		exp_push = 1'b1;
		bus_write('0, 8'h80);
		exp_push = 1'b0;
		loads_sent++;
		@(posedge clk);
		#1;
		check_value("readdata", 8'h01, readdata);   // busy from the edge after the load.
	endtask

	task automatic wait_idle();
		int cycles;
		cycles = 0;
		read = 1'b1;
		while (readdata[0] === 1'b1 && cycles < idle_limit)
		begin
			@(posedge clk);
			#1;
			cycles++;
		end
		read = 1'b0;
		if (readdata[0] !== 1'b0)
		begin
			tb_errors++;
			$display("busy did not drop within %0d clock cycles", idle_limit);
		end
		check_value("readdata", 8'h00, readdata);
		check_count("update_count", loads_sent, frames_seen);   // one strobe per load.
	endtask

	// random writes and loads during a transfer, none of them may reach the registers.
	task automatic writes_while_busy();
		logic [7:0] addr_bits;
		logic [7:0] data;
		for (int i = 0; i < num_outputs; i++)
		begin
			take_bits(3, addr_bits);
			take_bits(8, data);
			check_value("readdata", 8'h01, readdata);
			bus_write(addr_bits[addr_width-1:0], data);
		end
		bus_write('0, 8'h80);
	endtask

	initial
	begin
		repeat (timeout_cycles) @(posedge clk);
		$display("watchdog expired after %0d clock cycles, the run is stopped", timeout_cycles);
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		logic [7:0] addr_bits;
		clk = 1'b0;
		reset = 1'b1;
		write = 1'b0;
		read = 1'b0;
		address = '0;
		writedata = '0;
		exp_push = 1'b0;
		exp_frame = '0;
		tb_errors = 0;
		loads_sent = 0;
		lfsr = lfsr_seed;
		model_dis = '1;   // entries reset to zero, which reads as every output disabled.
		model_sel = '0;

		repeat (4) @(posedge clk);
		#1;
		check_value("readdata", 8'h00, readdata);
		check_value("cps_clk", 8'h01, {7'b0, cps_clk});
		check_value("cps_update_n", 8'h01, {7'b0, cps_update_n});
		check_value("cps_reset_n", 8'h00, {7'b0, cps_reset_n});
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		@(posedge clk);
		#1;
		check_value("readdata", 8'h00, readdata);
		check_value("cps_clk", 8'h01, {7'b0, cps_clk});
		check_value("cps_update_n", 8'h01, {7'b0, cps_update_n});
		check_value("cps_reset_n", 8'h01, {7'b0, cps_reset_n});
		check_value("cps_ce_n", 8'h00, {7'b0, cps_ce_n});

		issue_load();
		wait_idle();

		for (int r = 0; r < num_rounds; r++)
		begin
			for (int a = 0; a < num_outputs; a++)
			begin
				set_output(a[addr_width-1:0]);
			end
			issue_load();
			writes_while_busy();
			wait_idle();
			issue_load();   // must repeat the previous frame.
			wait_idle();
			take_bits(3, addr_bits);
			set_output(addr_bits[addr_width-1:0]);
			issue_load();
			wait_idle();
		end

		repeat (4) @(posedge clk);
		if (frames_pending != 0)
		begin
			tb_errors++;
			$display("%0d expected frames were never sent by the DUT", frames_pending);
		end
		assert_fails = dut_i.u_shifter.sva_i.fail_count;
		$display("frames %0d, frame errors %0d, testbench errors %0d, assertion failures %0d",
			frames_seen, frame_errors, tb_errors, assert_fails);
		if (frame_errors == 0 && tb_errors == 0 && assert_fails == 0)
		begin
			$display("TEST OK");
		end
		else
		begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: flist.f
hdl/crosspoint_pkg.sv
hdl/crosspoint_regs.sv
hdl/serial_shifter.sv
hdl/crosspoint_ctrl.sv
verification/crosspoint_sva.sv
verification/tb_frame_checker.sv
verification/tb_crosspoint_ctrl.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_crosspoint_ctrl
RTL_TOP    := crosspoint_ctrl
FLIST      := flist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := TEST OK
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
